// ==== verilog/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // ------------------------------------------------------------------
    // Widths

    typedef logic [7:0] seg_byte_t;   // Segments of one digit, or a bus byte
    typedef logic [7:0] key_vec_t;    // Key 0 at bit 0
    typedef logic [7:0] led_vec_t;    // One bit per LED
    typedef logic [2:0] digit_idx_t;  // Digit 0 to 7
    typedef logic [4:0] byte_idx_t;   // Byte within a frame phase

    // ------------------------------------------------------------------
    // TM1638 command bytes

    localparam seg_byte_t CMD_WRITE_AUTO = 8'h40;  // Data write with auto increment
    localparam seg_byte_t CMD_ADDR0      = 8'hC0;  // Display address 0
    localparam seg_byte_t CMD_DISPLAY_ON = 8'h8F;  // Display on at full brightness
    localparam seg_byte_t CMD_READ_KEYS  = 8'h42;  // Key scan read

    localparam int N_DISPLAY_BYTES = 16;
    localparam int N_KEY_BYTES     = 4;

    // ------------------------------------------------------------------
    // Bus timing in clk cycles

    localparam int HALF_BIT_CYCLES  = 25;  // 1 MHz serial clock from 50 MHz
    localparam int GAP_CYCLES       = 50;  // Strobe high between groups
    localparam int READ_TURN_CYCLES = 50;  // Read command to first read clock

    localparam int HALF_CNT_W = $clog2(HALF_BIT_CYCLES);
    localparam int WAIT_CNT_W = $clog2(GAP_CYCLES > READ_TURN_CYCLES ?
                                       GAP_CYCLES : READ_TURN_CYCLES);

    typedef logic [HALF_CNT_W-1:0] half_cnt_t;
    typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_CMD_WRITE,
        S_GAP1,
        S_ADDR,
        S_DATA,
        S_GAP2,
        S_CMD_ON,
        S_GAP3,
        S_CMD_READ,
        S_READ,
        S_GAP4
    } seq_state_t;

endpackage

`default_nettype wire

// ==== verilog/tm1638_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface tm1638_bus_if;

    import board_pkg::*;

    logic      start;    // One-cycle request for a byte
    logic      rx_mode;  // Read the byte instead of sending it
    seg_byte_t tx_byte;  // Taken on start
    logic      done;     // Byte finished
    seg_byte_t rx_byte;  // Valid with done

    modport seq (
        output start,
        output rx_mode,
        output tx_byte,
        input  done
    );

    modport shf (
        input  start,
        input  rx_mode,
        input  tx_byte,
        output done,
        output rx_byte
    );

endinterface

`default_nettype wire

// ==== verilog/tm1638_bit_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tm1638_bit_timer (
    input  logic clk,
    input  logic rst_n_i,
    input  logic run_i,
    output logic tick_o
);

    import board_pkg::*;

    localparam half_cnt_t RELOAD = half_cnt_t'(HALF_BIT_CYCLES - 1);

    half_cnt_t cnt;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt <= RELOAD;
        end else if (!run_i) begin
            cnt <= RELOAD;                // First tick a full half bit later
        end else if (cnt == '0) begin
            cnt <= RELOAD;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    assign tick_o = run_i && (cnt == '0);

endmodule

`default_nettype wire

// ==== verilog/tm1638_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tm1638_sequencer (
    input  logic                 clk,
    input  logic                 rst_n_i,
    tm1638_bus_if.seq            bus,
    input  board_pkg::seg_byte_t tx_data_i,
    output logic                 snap_o,
    output board_pkg::byte_idx_t byte_idx_o,
    output logic                 phase_is_data_o,
    output logic                 key_wr_o,
    output logic                 frame_done_o,
    output logic                 sio_stb_o
);

    import board_pkg::*;

    seq_state_t state;
    byte_idx_t  byte_cnt;
    wait_cnt_t  wait_cnt;
    logic       issued;     // Byte handed to the shifter until done
    logic       start_q;
    logic       stb_q;
    logic       rx_mode_q;

    logic xfer_state;
    logic gap_state;
    logic gap_end;
    logic turn_wait;
    logic launch;

    // ------------------------------------------------------------------
    // Decode

    assign xfer_state = (state == S_CMD_WRITE) || (state == S_ADDR) ||
                        (state == S_DATA) || (state == S_CMD_ON) ||
                        (state == S_CMD_READ) || (state == S_READ);

    assign gap_state  = (state == S_GAP1) || (state == S_GAP2) ||
                        (state == S_GAP3) || (state == S_GAP4);

    assign gap_end    = (wait_cnt == wait_cnt_t'(GAP_CYCLES - 2));

    // Bus turnaround before the first key byte
    assign turn_wait  = (state == S_READ) && (byte_cnt == '0) &&
                        (wait_cnt != wait_cnt_t'(READ_TURN_CYCLES - 2));

    assign launch     = xfer_state && !issued && !bus.done && !turn_wait;

    always_comb begin
        case (state)
            S_CMD_WRITE: bus.tx_byte = CMD_WRITE_AUTO;
            S_ADDR:      bus.tx_byte = CMD_ADDR0;
            S_DATA:      bus.tx_byte = tx_data_i;
            S_CMD_ON:    bus.tx_byte = CMD_DISPLAY_ON;
            S_CMD_READ:  bus.tx_byte = CMD_READ_KEYS;
            default:     bus.tx_byte = 8'hFF;   // Read bytes with the line released
        endcase
    end

    // ------------------------------------------------------------------
    // Frame state machine

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= S_IDLE;
            byte_cnt  <= '0;
            wait_cnt  <= '0;
            issued    <= 1'b0;
            start_q   <= 1'b0;
            stb_q     <= 1'b1;
            rx_mode_q <= 1'b1;                  // Keeps the data pin released
        end else begin
            start_q <= 1'b0;
            if (launch) begin
                start_q <= 1'b1;
                issued  <= 1'b1;
                stb_q   <= 1'b0;                // One cycle ahead of the clock
            end
            if (gap_state || turn_wait) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (bus.done) begin
                issued   <= 1'b0;
                wait_cnt <= '0;
            end

            case (state)
                S_IDLE: begin
                    rx_mode_q <= 1'b0;
                    state     <= S_CMD_WRITE;
                end
                S_CMD_WRITE: begin
                    if (bus.done) begin
                        stb_q <= 1'b1;
                        state <= S_GAP1;
                    end
                end
                S_GAP1: begin
                    if (gap_end) begin
                        wait_cnt <= '0;
                        state    <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (bus.done) begin
                        state <= S_DATA;        // Same strobe group
                    end
                end
                S_DATA: begin
                    if (bus.done) begin
                        if (byte_cnt == byte_idx_t'(N_DISPLAY_BYTES - 1)) begin
                            byte_cnt <= '0;
                            stb_q    <= 1'b1;
                            state    <= S_GAP2;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                S_GAP2: begin
                    if (gap_end) begin
                        wait_cnt <= '0;
                        state    <= S_CMD_ON;
                    end
                end
                S_CMD_ON: begin
                    if (bus.done) begin
                        stb_q <= 1'b1;
                        state <= S_GAP3;
                    end
                end
                S_GAP3: begin
                    if (gap_end) begin
                        wait_cnt <= '0;
                        state    <= S_CMD_READ;
                    end
                end
                S_CMD_READ: begin
                    if (bus.done) begin
                        rx_mode_q <= 1'b1;
                        state     <= S_READ;
                    end
                end
                S_READ: begin
                    if (bus.done) begin
                        if (byte_cnt == byte_idx_t'(N_KEY_BYTES - 1)) begin
                            byte_cnt <= '0;
                            stb_q    <= 1'b1;
                            state    <= S_GAP4;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                S_GAP4: begin
                    if (gap_end) begin
                        wait_cnt <= '0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign bus.start       = start_q;
    assign bus.rx_mode     = rx_mode_q;
    assign sio_stb_o       = stb_q;
    assign byte_idx_o      = byte_cnt;
    assign snap_o          = (state == S_IDLE);
    assign phase_is_data_o = (state == S_DATA);
    assign key_wr_o        = (state == S_READ) && bus.done;
    assign frame_done_o    = (state == S_GAP4) && gap_end;

endmodule

`default_nettype wire

// ==== verilog/tm1638_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tm1638_shifter (
    input  logic      clk,
    input  logic      rst_n_i,
    tm1638_bus_if.shf bus,
    input  logic      tick_i,
    output logic      run_o,
    output logic      sio_clk_o,
    output logic      sio_data_o,
    output logic      sio_data_oe_o,
    input  logic      sio_data_i
);

    import board_pkg::*;

    seg_byte_t  shreg;
    logic [3:0] edge_cnt;   // Half bits since start
    logic       busy;
    logic       sclk;
    logic       data_q;
    logic       done_q;

    logic       last_half;
    logic       rising;
    logic       falling;

    assign last_half = (edge_cnt == 4'd15);
    assign rising    = busy && tick_i && !last_half && !sclk;
    assign falling   = busy && tick_i && !last_half && sclk;

    // ------------------------------------------------------------------
    // Serial clock and control

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy     <= 1'b0;
            sclk     <= 1'b1;
            edge_cnt <= '0;
            data_q   <= 1'b1;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy) begin
                if (bus.start) begin
                    busy     <= 1'b1;
                    sclk     <= 1'b0;           // First falling edge
                    edge_cnt <= '0;
                    data_q   <= bus.tx_byte[0];
                end
            end else if (tick_i) begin
                edge_cnt <= edge_cnt + 1'b1;
                if (last_half) begin
                    busy   <= 1'b0;             // Clock stays high
                    done_q <= 1'b1;
                end else begin
                    sclk <= ~sclk;
                end
                if (falling && !bus.rx_mode) begin
                    data_q <= shreg[0];
                end
            end
        end
    end

    // LSB first in both directions
    always_ff @(posedge clk) begin
        if (!busy && bus.start) begin
            shreg <= {1'b0, bus.tx_byte[7:1]};
        end else if (falling && !bus.rx_mode) begin
            shreg <= {1'b0, shreg[7:1]};
        end else if (rising && bus.rx_mode) begin
            shreg <= {sio_data_i, shreg[7:1]};
        end
    end

    assign run_o         = busy;
    assign sio_clk_o     = sclk;
    assign sio_data_o    = data_q;
    assign sio_data_oe_o = ~bus.rx_mode;
    assign bus.done      = done_q;
    assign bus.rx_byte   = shreg;

endmodule

`default_nettype wire

// ==== verilog/tm1638_frame_data.sv ====
`timescale 1ns/1ps
`default_nettype none

module tm1638_frame_data (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  board_pkg::seg_byte_t abcdefgh_i [8],
    input  board_pkg::led_vec_t  led_i,
    input  logic                 snap_i,
    input  board_pkg::byte_idx_t byte_idx_i,
    input  logic                 phase_is_data_i,
    output board_pkg::seg_byte_t tx_data_o,
    input  board_pkg::seg_byte_t rx_byte_i,
    input  logic                 key_wr_i,
    input  logic                 frame_done_i,
    output board_pkg::key_vec_t  key_o,
    output logic                 key_valid_o
);

    import board_pkg::*;

    seg_byte_t  seg_q [8];
    led_vec_t   led_q;
    key_vec_t   key_work;
    digit_idx_t digit;
    logic [1:0] key_byte;

    // abcdefgh in, hgfedcba out
    function automatic seg_byte_t reverse_bits(input seg_byte_t v);
        seg_byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = v[7 - i];
        end
        return r;
    endfunction

    // ------------------------------------------------------------------
    // Display side

    always_ff @(posedge clk) begin
        if (snap_i) begin
            seg_q <= abcdefgh_i;
            led_q <= led_i;
        end
    end

    assign digit = byte_idx_i[3:1];

    always_comb begin
        if (!phase_is_data_i) begin
            tx_data_o = '0;
        end else if (byte_idx_i[0]) begin
            tx_data_o = {7'b0, led_q[digit]};   // LED in bit 0
        end else begin
            tx_data_o = reverse_bits(seg_q[digit]);
        end
    end

    // ------------------------------------------------------------------
    // Key side

    assign key_byte = byte_idx_i[1:0];

    always_ff @(posedge clk) begin
        if (key_wr_i) begin
            key_work[{1'b0, key_byte}] <= rx_byte_i[0];
            key_work[{1'b1, key_byte}] <= rx_byte_i[4];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            key_o       <= '0;
            key_valid_o <= 1'b0;
        end else begin
            key_valid_o <= frame_done_i;
            if (frame_done_i) begin
                key_o <= key_work;              // Published once per frame
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  board_pkg::seg_byte_t abcdefgh_i [8],
    input  board_pkg::led_vec_t  led_i,
    output board_pkg::key_vec_t  key_o,
    output logic                 key_valid_o,
    output logic                 sio_stb_o,
    output logic                 sio_clk_o,
    output logic                 sio_data_o,
    output logic                 sio_data_oe_o,
    input  logic                 sio_data_i
);

    import board_pkg::*;

    seg_byte_t tx_data;
    byte_idx_t byte_idx;
    logic      snap;
    logic      phase_is_data;
    logic      key_wr;
    logic      frame_done;
    logic      run;
    logic      tick;

    tm1638_bus_if bus_if ();

    // ------------------------------------------------------------------
    // Frame control

    tm1638_sequencer sequencer_inst (
        .clk             ( clk           ),
        .rst_n_i         ( rst_n_i       ),
        .bus             ( bus_if.seq    ),
        .tx_data_i       ( tx_data       ),
        .snap_o          ( snap          ),
        .byte_idx_o      ( byte_idx      ),
        .phase_is_data_o ( phase_is_data ),
        .key_wr_o        ( key_wr        ),
        .frame_done_o    ( frame_done    ),
        .sio_stb_o       ( sio_stb_o     )
    );

    tm1638_frame_data frame_data_inst (
        .clk             ( clk            ),
        .rst_n_i         ( rst_n_i        ),
        .abcdefgh_i      ( abcdefgh_i     ),
        .led_i           ( led_i          ),
        .snap_i          ( snap           ),
        .byte_idx_i      ( byte_idx       ),
        .phase_is_data_i ( phase_is_data  ),
        .tx_data_o       ( tx_data        ),
        .rx_byte_i       ( bus_if.rx_byte ),
        .key_wr_i        ( key_wr         ),
        .frame_done_i    ( frame_done     ),
        .key_o           ( key_o          ),
        .key_valid_o     ( key_valid_o    )
    );

    // ------------------------------------------------------------------
    // Serial link

    tm1638_shifter shifter_inst (
        .clk           ( clk           ),
        .rst_n_i       ( rst_n_i       ),
        .bus           ( bus_if.shf    ),
        .tick_i        ( tick          ),
        .run_o         ( run           ),
        .sio_clk_o     ( sio_clk_o     ),
        .sio_data_o    ( sio_data_o    ),
        .sio_data_oe_o ( sio_data_oe_o ),
        .sio_data_i    ( sio_data_i    )
    );

    tm1638_bit_timer bit_timer_inst (
        .clk     ( clk     ),
        .rst_n_i ( rst_n_i ),
        .run_i   ( run     ),
        .tick_o  ( tick    )
    );

endmodule

`default_nettype wire

// ==== test/tm1638_device_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tm1638_device_model (
    input  logic                 rst_n_i,
    input  logic                 stb_i,
    input  logic                 sclk_i,
    input  logic                 data_i,
    input  logic                 data_oe_i,
    input  board_pkg::key_vec_t  keys_i,
    output logic                 data_o,
    output logic                 drive_o,
    output logic                 in_read_o,
    output board_pkg::seg_byte_t byte_o,
    output logic                 first_o,
    output bit                   byte_evt_o
);

    import board_pkg::*;

    logic      stb_q;
    logic      sclk_q;
    int        rises;       // Rising clocks since the strobe fell
    int        rd_bit;
    seg_byte_t shreg;
    seg_byte_t cur;

    // Key b in bit 0, key b+4 in bit 4
    function automatic seg_byte_t key_scan_byte(input key_vec_t k, input int b);
        key_vec_t s;
        s = k >> b;
        return {3'b000, s[4], 3'b000, s[0]};
    endfunction

    initial begin
        stb_q     = 1'b1;
        sclk_q    = 1'b1;
        rises     = 0;
        shreg     = '0;
        data_o    = 1'b1;
        drive_o   = 1'b0;
        in_read_o = 1'b0;
        byte_o    = '0;
        first_o   = 1'b0;
    end

    // ------------------------------------------------------------------
    // Bus edges

    always @(posedge stb_i or negedge stb_i or posedge sclk_i or negedge sclk_i) begin
        if (!rst_n_i) begin
            rises     = 0;
            drive_o   = 1'b0;
            data_o    = 1'b1;
            in_read_o = 1'b0;
        end else if (stb_i && !stb_q) begin
            drive_o   = 1'b0;                     // Group over and line released
            data_o    = 1'b1;
            in_read_o = 1'b0;
        end else if (!stb_i && stb_q) begin
            rises = 0;                            // New group
        end else if (!stb_i && sclk_i && !sclk_q) begin
            shreg = {(data_oe_i ? data_i : data_o), shreg[7:1]};
            rises = rises + 1;
            if (rises % 8 == 0) begin
                byte_o  = shreg;
                first_o = (rises == 8);
                if (rises == 8 && shreg == 8'h42) begin
                    in_read_o = 1'b1;             // Key bytes follow
                end
                byte_evt_o = ~byte_evt_o;
            end
        end else if (!stb_i && !sclk_i && sclk_q && in_read_o) begin
            rd_bit  = rises - 8;
            cur     = key_scan_byte(keys_i, rd_bit / 8) >> (rd_bit % 8);
            data_o  = cur[0];
            drive_o = 1'b1;
        end
        stb_q  = stb_i;
        sclk_q = sclk_i;
    end

endmodule

`default_nettype wire

// ==== test/tb_board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;

    import board_pkg::*;

    localparam int N_ROWS         = 6;
    localparam int FRAME_BYTES    = 24;                 // 1 + 17 + 1 + 5
    localparam int TIMEOUT_CYCLES = N_ROWS * 3 * 12000;

    logic      clk;
    logic      rst_n;
    seg_byte_t seg_in [8];
    led_vec_t  led_in;
    key_vec_t  key_out;
    logic      key_valid;
    logic      sio_stb;
    logic      sio_clk;
    logic      dut_data;
    logic      dut_data_oe;
    logic      chip_data;
    key_vec_t  model_keys;
    logic      model_drive;
    logic      model_in_read;
    seg_byte_t model_byte;
    logic      model_first;
    bit        model_evt;

    seg_byte_t row_seg [N_ROWS][8];
    led_vec_t  row_led [N_ROWS];
    key_vec_t  row_key [N_ROWS];
    integer    seed;

    seg_byte_t log_byte [$];    // Every byte seen on the bus
    bit        log_first [$];   // Byte opened a strobe group
    int        cycles = 0;
    logic      valid_q = 1'b0;
    logic      seen_valid = 1'b0;

    board_top board_top_inst (
        .clk           ( clk         ),
        .rst_n_i       ( rst_n       ),
        .abcdefgh_i    ( seg_in      ),
        .led_i         ( led_in      ),
        .key_o         ( key_out     ),
        .key_valid_o   ( key_valid   ),
        .sio_stb_o     ( sio_stb     ),
        .sio_clk_o     ( sio_clk     ),
        .sio_data_o    ( dut_data    ),
        .sio_data_oe_o ( dut_data_oe ),
        .sio_data_i    ( chip_data   )
    );

    tm1638_device_model chip_inst (
        .rst_n_i    ( rst_n         ),
        .stb_i      ( sio_stb       ),
        .sclk_i     ( sio_clk       ),
        .data_i     ( dut_data      ),
        .data_oe_i  ( dut_data_oe   ),
        .keys_i     ( model_keys    ),
        .data_o     ( chip_data     ),
        .drive_o    ( model_drive   ),
        .in_read_o  ( model_in_read ),
        .byte_o     ( model_byte    ),
        .first_o    ( model_first   ),
        .byte_evt_o ( model_evt     )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                  // 50 MHz
    end

    // ------------------------------------------------------------------
    // Checks

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string what, input seg_byte_t got, input seg_byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0d ns: %s: got %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_keys(input string what, input key_vec_t got, input key_vec_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0d ns: %s: got %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR %0d ns: %s: got %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    // abcdefgh becomes hgfedcba
    function automatic seg_byte_t mirror_byte(input seg_byte_t v);
        return {v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]};
    endfunction

    function automatic seg_byte_t expected_key_byte(input key_vec_t k, input int b);
        key_vec_t s;
        s = k >> b;
        return {3'b000, s[4], 3'b000, s[0]};
    endfunction

    // ------------------------------------------------------------------
    // Stimulus

    task automatic fill_table();
        row_seg[0] = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0};
        row_led[0] = 8'hA5;
        row_key[0] = 8'hFF;                      // All keys down
        row_seg[1] = '{8'h01, 8'h80, 8'h0F, 8'hF0, 8'h3C, 8'hC3, 8'h55, 8'hAA};
        row_led[1] = 8'h5A;
        row_key[1] = 8'h00;                      // No key down
        seed = 32'h6312;
        for (int r = 2; r < N_ROWS; r++) begin
            for (int d = 0; d < 8; d++) begin
                row_seg[r][d] = seg_byte_t'($random(seed));
            end
            row_led[r] = led_vec_t'($random(seed));
            row_key[r] = key_vec_t'($random(seed));
        end
    endtask

    task automatic wait_key_valid();
        @(negedge clk);
        while (!key_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic check_frame(input int row, input int base);
        seg_byte_t exp_byte [FRAME_BYTES];
        bit        exp_first [FRAME_BYTES];
        led_vec_t  leds;
        for (int i = 0; i < FRAME_BYTES; i++) begin
            exp_first[i] = (i == 0) || (i == 1) || (i == 18) || (i == 19);
        end
        exp_byte[0] = 8'h40;
        exp_byte[1] = 8'hC0;
        for (int d = 0; d < 8; d++) begin
            exp_byte[2 + 2 * d] = mirror_byte(row_seg[row][d]);
            leds = row_led[row] >> d;
            exp_byte[3 + 2 * d] = {7'b0, leds[0]};
        end
        exp_byte[18] = 8'h8F;
        exp_byte[19] = 8'h42;
        for (int b = 0; b < 4; b++) begin
            exp_byte[20 + b] = expected_key_byte(row_key[row], b);
        end
        check_count($sformatf("row %0d bytes in one frame", row),
                    log_byte.size() - base, FRAME_BYTES);
        for (int i = 0; i < FRAME_BYTES; i++) begin
            check_count($sformatf("row %0d group start at byte %0d", row, i),
                        int'(log_first[base + i]), int'(exp_first[i]));
            check_byte($sformatf("row %0d frame byte %0d", row, i),
                       log_byte[base + i], exp_byte[i]);
        end
    endtask

    task automatic apply_row(input int row);
        int base;
        @(posedge clk);
        #2;
        model_keys = row_key[row];
        seg_in     = row_seg[row];
        led_in     = row_led[row];
        wait_key_valid();                         // Frame already under way
        base = log_byte.size();
        wait_key_valid();
        check_frame(row, base);
        check_keys($sformatf("row %0d key_o", row), key_out, row_key[row]);
    endtask

    // ------------------------------------------------------------------
    // Monitors

    always @(posedge model_evt or negedge model_evt) begin
        log_byte.push_back(model_byte);
        log_first.push_back(model_first);
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (!seen_valid && !key_valid) begin
                check_keys("key_o before the first frame", key_out, 8'h00);
            end
            check_count("key_valid_o high in two cycles", int'(key_valid && valid_q), 0);
            if (model_drive) begin
                check_count("data_oe while the chip drives", int'(dut_data_oe), 0);
            end
            if (!sio_stb && !model_in_read) begin
                check_count("data_oe in a write group", int'(dut_data_oe), 1);
            end
            if (key_valid) begin
                seen_valid = 1'b1;
            end
            valid_q = key_valid;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: tests did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    initial begin
        rst_n      = 1'b0;
        led_in     = '0;
        model_keys = '0;
        for (int d = 0; d < 8; d++) begin
            seg_in[d] = '0;
        end
        fill_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_count("sio_stb_o in reset", int'(sio_stb), 1);
        check_count("sio_clk_o in reset", int'(sio_clk), 1);
        check_count("sio_data_oe_o in reset", int'(dut_data_oe), 0);
        check_count("key_valid_o in reset", int'(key_valid), 0);
        check_keys("key_o in reset", key_out, 8'h00);
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            apply_row(r);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/board_pkg.sv
verilog/tm1638_bus_if.sv
verilog/tm1638_bit_timer.sv
verilog/tm1638_sequencer.sv
verilog/tm1638_shifter.sv
verilog/tm1638_frame_data.sv
verilog/board_top.sv
test/tm1638_device_model.sv
test/tb_board_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_board_top -Mdir obj_dir -f build.f
status=0
./obj_dir/Vtb_board_top > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
